/* project.f */
wb_periph_pkg.sv
wb_slave_if.sv
core_reset_gen.sv
wb_slave_decode.sv
gpio_regs.sv
ebr_ram.sv
wb_periph_top.sv
tb_wb_periph.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the peripheral bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_wb_periph -f project.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
   cat sim.log
   echo "Simulation exited with a failing status"
   exit 1
fi
cat sim.log

if grep -qx "No errors" sim.log; then
   exit 0
fi
echo "Pass message missing from sim.log"
exit 1

/* tb_wb_periph.sv */
// Testbench for the peripheral bus top level, checked against an LCG-driven reference model

`timescale 1ns/1ps

module tb_wb_periph;

   logic                             clk_125;
   logic                             rstn;
   logic [wb_periph_pkg::ADR_W-1:0]  wb_adr_i;
   logic [wb_periph_pkg::DATA_W-1:0] wb_dat_i;
   logic [wb_periph_pkg::SEL_W-1:0]  wb_sel_i;
   logic                             wb_we_i;
   logic                             wb_cyc_i;
   logic                             wb_stb_i;
   logic [wb_periph_pkg::DATA_W-1:0] wb_dat_o;
   logic                             wb_ack_o;
   logic [wb_periph_pkg::SW_W-1:0]   dip_switch_i;
   logic [wb_periph_pkg::LED_W-1:0]  led_n_o;

   // Reference model state
   logic [15:0] scratch_m;
   logic [13:0] led_m;
   logic [15:0] ram_m [0:1023];
   bit          touched [0:1023];
   int unsigned lcg_state;
   int          checks;
   int          errors;
   int          test_base;

   wb_periph_top uut (.*);

   always #4 clk_125 = ~clk_125;

   // ========================================================================
   // Helpers
   // ========================================================================
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Byte-lane write rule shared by scratch, LED and RAM
   function automatic logic [15:0] merge_lanes(input logic [15:0] old_v, input logic [15:0] new_v,
                                                input logic [1:0] sel);
      logic [15:0] res;
      res = old_v;
      if (sel[0]) res[7:0] = new_v[7:0];
      if (sel[1]) res[15:8] = new_v[15:8];
      return res;
   endfunction

   function automatic logic [31:0] gpio_addr(input int off);
      return wb_periph_pkg::GPIO_BASE + 32'(off * 2);
   endfunction

   function automatic logic [31:0] ram_addr(input int off);
      return wb_periph_pkg::EBR_BASE + 32'(off * 2);
   endfunction

   task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      assert (act === exp) else begin
         $display("FAILED %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      $display("Test %s finished with %0d errors", name, errors - test_base);
      test_base = errors;
   endtask

   // One bus cycle, entered and left on a falling edge
   task automatic bus_access(input logic we, input logic [31:0] adr, input logic [15:0] dat,
                             input logic [1:0] sel, output logic [15:0] rdata);
      int wait_cnt;
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_sel_i = sel;
      wb_we_i  = we;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wait_cnt = 0;
      do begin
         @(negedge clk_125);
         wait_cnt++;
      end while (!wb_ack_o && wait_cnt < 16);
      if (!wb_ack_o) begin
         $display("Timeout, no acknowledge within 16 cycles at address %h", adr);
         $display("Errors found");
         $finish;
      end else begin
         rdata    = wb_dat_o;
         wb_stb_i = 1'b0;
         wb_cyc_i = 1'b0;
         wb_we_i  = 1'b0;
         // Idle cycle between requests
         @(negedge clk_125);
      end
   endtask

   // ========================================================================
   // Test sequence
   // ========================================================================
   initial begin
      logic [15:0] rd;
      logic [15:0] d;
      logic [31:0] r;
      logic [31:0] r2;
      logic [9:0]  off;
      logic [1:0]  sel;
      clk_125 = 1'b0;
      rstn = 1'b0;
      wb_adr_i = gpio_addr(0);
      wb_dat_i = '0;
      wb_sel_i = 2'b11;
      wb_we_i = 1'b0;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      dip_switch_i = '0;
      lcg_state = 76;
      checks = 0;
      errors = 0;
      test_base = 0;
      scratch_m = '0;
      led_m = '0;

      // Request held pending through reset, nothing may answer it
      for (int i = 0; i < wb_periph_pkg::RESET_HOLD_CYCLES + 16; i++) begin
         @(negedge clk_125);
         if (i == 7) rstn = 1'b1;
         if (i == wb_periph_pkg::RESET_HOLD_CYCLES) begin
            wb_cyc_i = 1'b0;
            wb_stb_i = 1'b0;
         end
         check_value("wb_ack_o", 16'h0000, 16'(wb_ack_o));
         check_value("led_n_o", {2'b00, {14{1'b1}}}, {2'b00, led_n_o});
      end
      bus_access(1'b0, gpio_addr(wb_periph_pkg::REG_ID), 16'h0, 2'b11, rd);
      check_value("wb_dat_o", wb_periph_pkg::GPIO_ID_VALUE, rd);
      finish_test("reset_id");

      for (int i = 0; i < 40; i++) begin
         r = lcg_next();
         sel = r[31:30];
         d = r[23:8];
         scratch_m = merge_lanes(scratch_m, d, sel);
         bus_access(1'b1, gpio_addr(wb_periph_pkg::REG_SCRATCH), d, sel, rd);
         bus_access(1'b0, gpio_addr(wb_periph_pkg::REG_SCRATCH), 16'h0, 2'b11, rd);
         check_value("wb_dat_o", scratch_m, rd);
      end
      finish_test("scratch");

      for (int i = 0; i < 20; i++) begin
         r = lcg_next();
         sel = r[29:28];
         d = r[27:12];
         led_m = 14'(merge_lanes({2'b00, led_m}, d, sel));
         bus_access(1'b1, gpio_addr(wb_periph_pkg::REG_LED), d, sel, rd);
         check_value("led_n_o", {2'b00, ~led_m}, {2'b00, led_n_o});
         bus_access(1'b0, gpio_addr(wb_periph_pkg::REG_LED), 16'h0, 2'b11, rd);
         check_value("wb_dat_o", {2'b00, led_m}, rd);
      end
      finish_test("leds");

      for (int i = 0; i < 10; i++) begin
         r = lcg_next();
         dip_switch_i = r[31:24];
         bus_access(1'b0, gpio_addr(wb_periph_pkg::REG_SWITCH), 16'h0, 2'b11, rd);
         check_value("wb_dat_o", {8'h00, r[31:24]}, rd);
      end
      finish_test("switches");

      // Scratch value that the RAM writes below must leave alone
      r = lcg_next();
      scratch_m = r[15:0];
      bus_access(1'b1, gpio_addr(wb_periph_pkg::REG_SCRATCH), scratch_m, 2'b11, rd);

      // Known fill first, so partial lane writes never meet unset RAM
      for (int i = 0; i < 1024; i++) begin
         ram_m[i] = {i[5:0], i[9:0]} ^ 16'h5A3C;
         touched[i] = 1'b0;
         bus_access(1'b1, ram_addr(i), ram_m[i], 2'b11, rd);
      end
      for (int i = 0; i < 200; i++) begin
         r = lcg_next();
         r2 = lcg_next();
         off = r[25:16];
         sel = r2[31:30];
         d = r2[23:8];
         ram_m[off] = merge_lanes(ram_m[off], d, sel);
         touched[off] = 1'b1;
         bus_access(1'b1, ram_addr(int'(off)), d, sel, rd);
      end
      bus_access(1'b0, gpio_addr(wb_periph_pkg::REG_SCRATCH), 16'h0, 2'b11, rd);
      check_value("wb_dat_o", scratch_m, rd);
      scratch_m = r2[15:0];
      bus_access(1'b1, gpio_addr(wb_periph_pkg::REG_SCRATCH), scratch_m, 2'b11, rd);
      for (int i = 0; i < 1024; i++) begin
         if (touched[i]) begin
            bus_access(1'b0, ram_addr(i), 16'h0, 2'b11, rd);
            check_value("wb_dat_o", ram_m[i], rd);
         end
      end
      bus_access(1'b0, gpio_addr(wb_periph_pkg::REG_SCRATCH), 16'h0, 2'b11, rd);
      check_value("wb_dat_o", scratch_m, rd);
      finish_test("ram");

      // Upper half never zero, so the address misses both windows
      for (int i = 0; i < 20; i++) begin
         r = lcg_next();
         r2 = lcg_next();
         // Writes aim at word offset 1, where a misrouted write would hit scratch or RAM
         if (i[0]) r2[10:1] = 10'd1;
         bus_access(i[0], {r[31:16] | 16'h0001, r2[15:0]}, r2[31:16], 2'b11, rd);
         if (!i[0]) check_value("wb_dat_o", 16'h0000, rd);
      end
      bus_access(1'b0, gpio_addr(wb_periph_pkg::REG_SCRATCH), 16'h0, 2'b11, rd);
      check_value("wb_dat_o", scratch_m, rd);
      for (int i = 0; i < 1024; i++) begin
         bus_access(1'b0, ram_addr(i), 16'h0, 2'b11, rd);
         check_value("wb_dat_o", ram_m[i], rd);
      end
      finish_test("unmapped");

      $display("Checks %0d, failed %0d", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

/* wb_periph_top.sv */
// Top level of the peripheral bus with reset stretcher, address decoder, GPIO and RAM

`timescale 1ns/1ps

module wb_periph_top (
   input  logic                             clk_125,
   input  logic                             rstn,
   input  logic [wb_periph_pkg::ADR_W-1:0]  wb_adr_i,
   input  logic [wb_periph_pkg::DATA_W-1:0] wb_dat_i,
   input  logic [wb_periph_pkg::SEL_W-1:0]  wb_sel_i,
   input  logic                             wb_we_i,
   input  logic                             wb_cyc_i,
   input  logic                             wb_stb_i,
   output logic [wb_periph_pkg::DATA_W-1:0] wb_dat_o,
   output logic                             wb_ack_o,
   input  logic [wb_periph_pkg::SW_W-1:0]   dip_switch_i,
   output logic [wb_periph_pkg::LED_W-1:0]  led_n_o
);

   logic core_rst_n;

   wb_slave_if gpio_bus ();
   wb_slave_if ebr_bus ();

   // ========================================================================
   // Reset and bus decode
   // ========================================================================
   core_reset_gen u_reset (
      .clk_125      (clk_125),
      .rstn         (rstn),
      .core_rst_n_o (core_rst_n)
   );

   wb_slave_decode u_decode (
      .clk_125  (clk_125),
      .rstn     (core_rst_n),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i),
      .wb_we_i  (wb_we_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o),
      .gpio_if  (gpio_bus.decoder),
      .ebr_if   (ebr_bus.decoder)
   );

   // Slaves
   gpio_regs u_gpio (
      .clk_125      (clk_125),
      .rstn         (core_rst_n),
      .bus          (gpio_bus.slave),
      .dip_switch_i (dip_switch_i),
      .led_n_o      (led_n_o)
   );

   ebr_ram u_ebr (
      .clk_125 (clk_125),
      .rstn    (core_rst_n),
      .bus     (ebr_bus.slave)
   );

endmodule

/* ebr_ram.sv */
// Embedded block RAM slave with 16-bit words and byte-lane writes

`timescale 1ns/1ps

module ebr_ram (
   input  logic      clk_125,
   input  logic      rstn,
   wb_slave_if.slave bus
);

   logic [wb_periph_pkg::DATA_W-1:0] mem [0:(2**wb_periph_pkg::EBR_DEPTH_BITS)-1];

   // ========================================================================
   // Array write, one pass per lane
   // ========================================================================
   always_ff @(posedge clk_125) begin
      if (bus.stb && bus.we && !bus.ack) begin
         for (int lane = 0; lane < wb_periph_pkg::SEL_W; lane++) begin
            if (bus.sel[lane]) begin
               mem[bus.adr][lane*8 +: 8] <= bus.dat_w[lane*8 +: 8];
            end
         end
      end
   end

   // Output register and ack, loaded together
   always_ff @(posedge clk_125 or negedge rstn) begin
      if (!rstn) begin
         bus.ack   <= 1'b0;
         bus.dat_r <= '0;
      end else begin
         bus.ack <= bus.stb && !bus.ack;
         if (bus.stb && !bus.ack) begin
            bus.dat_r <= mem[bus.adr];
         end
      end
   end

endmodule

/* gpio_regs.sv */
// GPIO register block with ID, scratch, switch input and LED output registers

`timescale 1ns/1ps

module gpio_regs (
   input  logic                             clk_125,
   input  logic                             rstn,
   wb_slave_if.slave                        bus,
   input  logic [wb_periph_pkg::SW_W-1:0]   dip_switch_i,
   output logic [wb_periph_pkg::LED_W-1:0]  led_n_o
);

   wb_periph_pkg::gpio_reg_e         reg_sel;
   logic [wb_periph_pkg::DATA_W-1:0] scratch_q;
   logic [wb_periph_pkg::LED_W-1:0]  led_q;
   logic [wb_periph_pkg::DATA_W-1:0] rd_data;
   logic                             wr_en;

   assign reg_sel = wb_periph_pkg::gpio_reg_e'(bus.adr);
   // Write once, in the cycle before ack
   assign wr_en   = bus.stb && bus.we && !bus.ack;

   // Read mux, unknown offsets read zero
   always_comb begin
      case (reg_sel)
         wb_periph_pkg::REG_ID:      rd_data = wb_periph_pkg::GPIO_ID_VALUE;
         wb_periph_pkg::REG_SCRATCH: rd_data = scratch_q;
         wb_periph_pkg::REG_SWITCH:
            rd_data = {{(wb_periph_pkg::DATA_W - wb_periph_pkg::SW_W){1'b0}}, dip_switch_i};
         wb_periph_pkg::REG_LED:
            rd_data = {{(wb_periph_pkg::DATA_W - wb_periph_pkg::LED_W){1'b0}}, led_q};
         default:                    rd_data = '0;
      endcase
   end

   // ========================================================================
   // Register writes and bus response
   // ========================================================================
   always_ff @(posedge clk_125 or negedge rstn) begin
      if (!rstn) begin
         scratch_q <= '0;
         led_q     <= '0;
         bus.ack   <= 1'b0;
         bus.dat_r <= '0;
      end else begin
         bus.ack <= bus.stb && !bus.ack;
         if (bus.stb && !bus.ack) begin
            bus.dat_r <= rd_data;
         end
         if (wr_en && (reg_sel == wb_periph_pkg::REG_SCRATCH)) begin
            if (bus.sel[0]) scratch_q[7:0]  <= bus.dat_w[7:0];
            if (bus.sel[1]) scratch_q[15:8] <= bus.dat_w[15:8];
         end
         if (wr_en && (reg_sel == wb_periph_pkg::REG_LED)) begin
            // Upper lane only holds the top LED bits
            if (bus.sel[0]) led_q[7:0] <= bus.dat_w[7:0];
            if (bus.sel[1]) led_q[wb_periph_pkg::LED_W-1:8] <= bus.dat_w[wb_periph_pkg::LED_W-1:8];
         end
      end
   end

   // LEDs are active low on the board
   assign led_n_o = ~led_q;

endmodule

/* wb_slave_decode.sv */
// Address decoder that routes one bus master to the GPIO and RAM slaves and merges the response

`timescale 1ns/1ps

module wb_slave_decode (
   input  logic                                clk_125,
   input  logic                                rstn,
   input  logic [wb_periph_pkg::ADR_W-1:0]     wb_adr_i,
   input  logic [wb_periph_pkg::DATA_W-1:0]    wb_dat_i,
   input  logic [wb_periph_pkg::SEL_W-1:0]     wb_sel_i,
   input  logic                                wb_we_i,
   input  logic                                wb_cyc_i,
   input  logic                                wb_stb_i,
   output logic [wb_periph_pkg::DATA_W-1:0]    wb_dat_o,
   output logic                                wb_ack_o,
   wb_slave_if.decoder                         gpio_if,
   wb_slave_if.decoder                         ebr_if
);

   wb_periph_pkg::slave_e slv_sel;
   logic                  bus_req;
   logic                  none_ack;

   assign bus_req = wb_cyc_i & wb_stb_i;

   // ========================================================================
   // Window compare on the byte address
   // ========================================================================
   always_comb begin
      if (wb_adr_i[wb_periph_pkg::ADR_W-1:wb_periph_pkg::GPIO_SPAN_BITS] ==
          wb_periph_pkg::GPIO_BASE[wb_periph_pkg::ADR_W-1:wb_periph_pkg::GPIO_SPAN_BITS]) begin
         slv_sel = wb_periph_pkg::SLV_GPIO;
      end else if (wb_adr_i[wb_periph_pkg::ADR_W-1:wb_periph_pkg::EBR_DEPTH_BITS+1] ==
                   wb_periph_pkg::EBR_BASE[wb_periph_pkg::ADR_W-1:wb_periph_pkg::EBR_DEPTH_BITS+1]
                  ) begin
         // RAM window spans two bytes per word
         slv_sel = wb_periph_pkg::SLV_EBR;
      end else begin
         slv_sel = wb_periph_pkg::SLV_NONE;
      end
   end

   // Request fan-out, only stb is gated per slave
   assign gpio_if.adr   = wb_adr_i[wb_periph_pkg::SLV_ADR_W:1];
   assign gpio_if.dat_w = wb_dat_i;
   assign gpio_if.sel   = wb_sel_i;
   assign gpio_if.we    = wb_we_i;
   assign gpio_if.stb   = bus_req && (slv_sel == wb_periph_pkg::SLV_GPIO);

   assign ebr_if.adr    = wb_adr_i[wb_periph_pkg::SLV_ADR_W:1];
   assign ebr_if.dat_w  = wb_dat_i;
   assign ebr_if.sel    = wb_sel_i;
   assign ebr_if.we     = wb_we_i;
   assign ebr_if.stb    = bus_req && (slv_sel == wb_periph_pkg::SLV_EBR);

   // Unmapped addresses get their own ack so the master never hangs
   always_ff @(posedge clk_125 or negedge rstn) begin
      if (!rstn) begin
         none_ack <= 1'b0;
      end else begin
         none_ack <= bus_req && (slv_sel == wb_periph_pkg::SLV_NONE) && !none_ack;
      end
   end

   // ========================================================================
   // Response merge
   // ========================================================================
   assign wb_ack_o = gpio_if.ack | ebr_if.ack | none_ack;

   always_comb begin
      case (slv_sel)
         wb_periph_pkg::SLV_GPIO: wb_dat_o = gpio_if.dat_r;
         wb_periph_pkg::SLV_EBR:  wb_dat_o = ebr_if.dat_r;
         default:                 wb_dat_o = '0;
      endcase
   end

endmodule

/* core_reset_gen.sv */
// Stretches the external reset so the core reset stays active for a fixed hold time

`timescale 1ns/1ps

module core_reset_gen (
   input  logic clk_125,
   input  logic rstn,
   output logic core_rst_n_o
);

   logic [$clog2(wb_periph_pkg::RESET_HOLD_CYCLES + 1)-1:0] hold_cnt;

   // Count clocks after rstn rises, then release and freeze
   always_ff @(posedge clk_125 or negedge rstn) begin
      if (!rstn) begin
         hold_cnt     <= '0;
         core_rst_n_o <= 1'b0;
      end else begin
         if (hold_cnt == wb_periph_pkg::RESET_HOLD_CYCLES) begin
            core_rst_n_o <= 1'b1;
         end else begin
            hold_cnt <= hold_cnt + 1'b1;
         end
      end
   end

endmodule

/* wb_slave_if.sv */
// One decoded slave access from the address decoder and the slave's response

`timescale 1ns/1ps

interface wb_slave_if;

   // Request, driven by the decoder
   logic [wb_periph_pkg::SLV_ADR_W-1:0] adr;
   logic [wb_periph_pkg::DATA_W-1:0]    dat_w;
   logic [wb_periph_pkg::SEL_W-1:0]     sel;
   logic                                we;
   logic                                stb;

   // Response, driven by the slave
   logic [wb_periph_pkg::DATA_W-1:0]    dat_r;
   logic                                ack;

   modport decoder (output adr, dat_w, sel, we, stb, input dat_r, ack);

   modport slave (input adr, dat_w, sel, we, stb, output dat_r, ack);

endinterface

/* wb_periph_pkg.sv */
// Shared bus widths, address map, reset hold time and enum types for the peripheral bus

package wb_periph_pkg;

   // ========================================================================
   // Bus widths
   // ========================================================================
   localparam int DATA_W = 16;
   localparam int SEL_W  = 2;
   localparam int ADR_W  = 32;

   // ========================================================================
   // Address map
   // ========================================================================
   // GPIO window is 4 KB
   localparam logic [ADR_W-1:0] GPIO_BASE      = 32'h0000_0000;
   localparam int               GPIO_SPAN_BITS = 12;
   // RAM window is 1024 words of 16 bits
   localparam logic [ADR_W-1:0] EBR_BASE       = 32'h0000_4000;
   localparam int               EBR_DEPTH_BITS = 10;
   localparam int               SLV_ADR_W      = EBR_DEPTH_BITS;

   // Board IO and constants
   localparam int                LED_W             = 14;
   localparam int                SW_W              = 8;
   localparam logic [DATA_W-1:0] GPIO_ID_VALUE     = 16'hEC30;
   localparam int                RESET_HOLD_CYCLES = 128;

   // Decode target of one access
   typedef enum logic [1:0] {SLV_GPIO, SLV_EBR, SLV_NONE} slave_e;

   // GPIO word offsets
   typedef enum logic [SLV_ADR_W-1:0] {
      REG_ID      = 0,
      REG_SCRATCH = 1,
      REG_SWITCH  = 2,
      REG_LED     = 3
   } gpio_reg_e;

endpackage
